// File: sim.f
encPackage.sv
chunkSequencer.sv
crcParityEncoder.sv
parityMerger.sv
encWidthConverter.sv
eccEncodeTop.sv
tbEccEncode.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbEccEncode
FILELIST = sim.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: tbEccEncode.sv
`timescale 1ns/1ps

module tbEccEncode
    import encPackage::*;
();

    localparam int WaitLimit = 100;

    logic      iClock;
    logic      reset;
    logic      iSrcValid;
    halfWord_t iSrcData;
    logic      srcReady;
    logic      oBeatValid;
    beat_t     oBeat;
    logic      oDataLast;
    logic      oParityLast;
    logic      iDstReady;

    int          errorCount;
    logic [31:0] lfsrState;
    halfWord_t   txWords[$];
    beat_t       expBeat[$];
    logic        expDataLast[$];
    logic        expParityLast[$];
    beat_t       gotBeats[$];

    eccEncodeTop i_eccEncodeTop (
        .iClock      (iClock),
        .reset       (reset),
        .iSrcValid   (iSrcValid),
        .iSrcData    (iSrcData),
        .srcReady    (srcReady),
        .oBeatValid  (oBeatValid),
        .oBeat       (oBeat),
        .oDataLast   (oDataLast),
        .oParityLast (oParityLast),
        .iDstReady   (iDstReady)
    );

    initial
    begin
        iClock = 1'b0;
        forever
        begin
            #50 iClock = ~iClock;
        end
    end

    // One step of the Galois LFSR yields one random bit.
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit)
        begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int n = 0; n < count; n++)
        begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    // CRC-16 over the chunk, each word fed MSB first.
    function automatic crc_t crcModel(input halfWord_t words[ChunkDataWords]);
        crc_t      crc;
        halfWord_t word;
        crc = CrcInit;
        foreach (words[k])
        begin
            word = words[k];
            repeat (16)
            begin
                if (crc[15] != word[15])
                begin
                    crc = (crc << 1) ^ CrcPoly;
                end
                else
                begin
                    crc = crc << 1;
                end
                word = word << 1;
            end
        end
        return crc;
    endfunction

    task automatic compareBeat(input string testName, input beat_t expected, input beat_t actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic compareFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAIL %s: expected %b, actual %b", testName, expected, actual);
        end
    endtask

    // Seven words go to the host queue, four beats to the scoreboard.
    task automatic addChunk(input logic useRandom, input halfWord_t seedWord);
        halfWord_t words[ChunkDataWords];
        crc_t      parity;
        for (int i = 0; i < ChunkDataWords; i++)
        begin
            words[i] = useRandom ? halfWord_t'(randomBits(16))
                                 : seedWord ^ halfWord_t'(i * 4369);
            txWords.push_back(words[i]);
        end
        parity = crcModel(words);
        for (int b = 0; b < 3; b++)
        begin
            expBeat.push_back({words[2 * b], words[2 * b + 1]});
            expDataLast.push_back(1'b0);
            expParityLast.push_back(1'b0);
        end
        expBeat.push_back({words[6], parity});
        expDataLast.push_back(1'b1);
        expParityLast.push_back(1'b1);
    endtask

    task automatic driveWords(input logic withGaps);
        int gapCycles;
        int waitCycles;
        foreach (txWords[i])
        begin
            gapCycles = withGaps ? int'(randomBits(2)) : 0;
            repeat (gapCycles)
            begin
                @(negedge iClock);
                iSrcValid = 1'b0;
            end
            @(negedge iClock);
            iSrcValid = 1'b1;
            iSrcData  = txWords[i];
            #10;
            waitCycles = 0;
            while (!srcReady && waitCycles < WaitLimit)
            begin
                @(negedge iClock);
                #10;
                waitCycles++;
            end
            if (!srcReady)
            begin
                errorCount++;
                $display("Timeout: host word %0d was never accepted", i);
                break;
            end
        end
        @(negedge iClock);
        iSrcValid = 1'b0;
    endtask

    task automatic collectBeats(input string testName, input logic withStalls);
        beat_t heldBeat;
        logic  holding;
        int    idleCycles;
        holding    = 1'b0;
        idleCycles = 0;
        while (expBeat.size() > 0 && idleCycles < WaitLimit)
        begin
            @(negedge iClock);
            iDstReady = withStalls ? nextBit() : 1'b1;
            #10;
            // A beat that was refused must still be offered unchanged.
            if (holding)
            begin
                compareFlag({testName, " held valid"}, 1'b1, oBeatValid);
                compareBeat({testName, " held beat"}, heldBeat, oBeat);
            end
            holding = oBeatValid && !iDstReady;
            heldBeat = oBeat;
            if (oBeatValid && iDstReady)
            begin
                compareBeat(testName, expBeat.pop_front(), oBeat);
                compareFlag({testName, " dataLast"}, expDataLast.pop_front(), oDataLast);
                compareFlag({testName, " parityLast"}, expParityLast.pop_front(), oParityLast);
                gotBeats.push_back(oBeat);
                idleCycles = 0;
            end
            else
            begin
                idleCycles++;
            end
        end
        if (expBeat.size() > 0)
        begin
            errorCount++;
            $display("Timeout in %s: %0d beats never arrived", testName, expBeat.size());
        end
        repeat (4)
        begin
            @(negedge iClock);
            iDstReady = 1'b1;
            #10;
            if (oBeatValid)
            begin
                errorCount++;
                $display("%s: a beat appeared after the last expected one", testName);
            end
        end
    endtask

    task automatic runTraffic(input string testName, input logic withGaps,
                              input logic withStalls);
        gotBeats.delete();
        fork
            driveWords(withGaps);
            collectBeats(testName, withStalls);
        join
        txWords.delete();
    endtask

    task automatic resetState();
        @(negedge iClock);
        #10;
        compareFlag("resetState oBeatValid", 1'b0, oBeatValid);
        compareFlag("resetState oDataLast", 1'b0, oDataLast);
        compareFlag("resetState oParityLast", 1'b0, oParityLast);
        compareFlag("resetState srcReady", 1'b1, srcReady);
    endtask

    // The lower half of the fourth beat is compared with the model CRC.
    task automatic singleChunk();
        addChunk(1'b0, 16'h1234);
        runTraffic("singleChunk", 1'b0, 1'b0);
    endtask

    task automatic backToBackChunks();
        repeat (4)
        begin
            addChunk(1'b1, '0);
        end
        runTraffic("backToBackChunks", 1'b0, 1'b0);
    endtask

    task automatic downstreamStall();
        repeat (3)
        begin
            addChunk(1'b1, '0);
        end
        runTraffic("downstreamStall", 1'b0, 1'b1);
    endtask

    task automatic sourceGaps();
        logic [31:0] savedState;
        beat_t       refBeats[$];
        savedState = lfsrState;
        repeat (2)
        begin
            addChunk(1'b1, '0);
        end
        runTraffic("sourceGaps reference", 1'b0, 1'b0);
        refBeats = gotBeats;
        // Rewind the LFSR so the same data goes out again, now with gaps.
        lfsrState = savedState;
        repeat (2)
        begin
            addChunk(1'b1, '0);
        end
        runTraffic("sourceGaps", 1'b1, 1'b0);
        if (gotBeats.size() != refBeats.size())
        begin
            errorCount++;
            $display("sourceGaps returned %0d beats, the gap-free run returned %0d",
                     gotBeats.size(), refBeats.size());
        end
        else
        begin
            foreach (refBeats[i])
            begin
                compareBeat("sourceGaps against gap-free", refBeats[i], gotBeats[i]);
            end
        end
    endtask

    initial
    begin
        errorCount = 0;
        lfsrState  = 32'h141a_4b48;
        reset      = 1'b1;
        iSrcValid  = 1'b0;
        iSrcData   = '0;
        iDstReady  = 1'b1;
        repeat (8)
        begin
            @(negedge iClock);
        end
        reset = 1'b0;
        resetState();
        singleChunk();
        backToBackChunks();
        downstreamStall();
        sourceGaps();
        $display("Test run finished with %0d errors", errorCount);
        if (errorCount == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: eccEncodeTop.sv
`timescale 1ns/1ps

module eccEncodeTop
    import encPackage::*;
(
    input  logic      iClock,
    input  logic      reset,
    input  logic      iSrcValid,
    input  halfWord_t iSrcData,
    output logic      srcReady,
    output logic      oBeatValid,
    output beat_t     oBeat,
    output logic      oDataLast,
    output logic      oParityLast,
    input  logic      iDstReady
);

    logic    seqStrobe;
    stream_t seqWord;
    crc_t    parityWord;
    logic    mergedValid;
    stream_t mergedWord;
    logic    convReady;

    chunkSequencer i_chunkSequencer (
        .iClock    (iClock),
        .reset     (reset),
        .iSrcValid (iSrcValid),
        .iSrcData  (iSrcData),
        .srcReady  (srcReady),
        .seqStrobe (seqStrobe),
        .seqWord   (seqWord)
    );

    crcParityEncoder i_crcParityEncoder (
        .iClock     (iClock),
        .reset      (reset),
        .seqStrobe  (seqStrobe),
        .seqWord    (seqWord),
        .parityWord (parityWord)
    );

    parityMerger i_parityMerger (
        .iClock      (iClock),
        .reset       (reset),
        .iSrcValid   (iSrcValid),
        .seqWord     (seqWord),
        .parityWord  (parityWord),
        .convReady   (convReady),
        .srcReady    (srcReady),
        .mergedValid (mergedValid),
        .mergedWord  (mergedWord)
    );

    encWidthConverter i_encWidthConverter (
        .iClock      (iClock),
        .reset       (reset),
        .mergedValid (mergedValid),
        .mergedWord  (mergedWord),
        .convReady   (convReady),
        .oBeatValid  (oBeatValid),
        .oBeat       (oBeat),
        .oDataLast   (oDataLast),
        .oParityLast (oParityLast),
        .iDstReady   (iDstReady)
    );

endmodule

// File: encWidthConverter.sv
`timescale 1ns/1ps

module encWidthConverter
    import encPackage::*;
(
    input  logic    iClock,
    input  logic    reset,
    input  logic    mergedValid,
    input  stream_t mergedWord,
    output logic    convReady,
    output logic    oBeatValid,
    output beat_t   oBeat,
    output logic    oDataLast,
    output logic    oParityLast,
    input  logic    iDstReady
);

    convState_t state;
    convState_t nextState;
    stream_t    inputReg;
    stream_t    shiftReg;
    logic       beatValid;

    always_ff @(posedge iClock)
    begin
        if (reset)
        begin
            state <= Idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Input holds the first word of a pair, Shift and OutPause present a full beat.
    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
            begin
                nextState = mergedValid ? Input : Idle;
            end
            Input:
            begin
                nextState = mergedValid ? Shift : InPause;
            end
            InPause:
            begin
                nextState = mergedValid ? Shift : InPause;
            end
            Shift, OutPause:
            begin
                if (!iDstReady)
                begin
                    nextState = OutPause;
                end
                else if (mergedValid)
                begin
                    nextState = Input;
                end
                else
                begin
                    nextState = Idle;
                end
            end
            default:
            begin
                nextState = Idle;
            end
        endcase
    end

    // A word is consumed only when it moves into the input register.
    always_ff @(posedge iClock)
    begin
        if (nextState == Input || nextState == Shift)
        begin
            inputReg <= mergedWord;
        end
        if (nextState == Shift)
        begin
            shiftReg <= inputReg;
        end
    end

    always_ff @(posedge iClock)
    begin
        if (reset)
        begin
            beatValid <= 1'b0;
        end
        else
        begin
            beatValid <= (nextState == Shift) || (nextState == OutPause);
        end
    end

    assign convReady   = (nextState != OutPause);
    assign oBeatValid  = beatValid;
    assign oBeat       = {shiftReg.data, inputReg.data};
    assign oDataLast   = beatValid && (shiftReg.dataLast || inputReg.dataLast);
    assign oParityLast = beatValid && (shiftReg.parityLast || inputReg.parityLast);

    // A stalled beat keeps its value and its valid until the channel takes it.
    heldBeatStable: assert property (
        @(posedge iClock) disable iff (reset)
        (oBeatValid && !iDstReady) |=> (oBeatValid && $stable(oBeat))
    );

endmodule

// File: parityMerger.sv
`timescale 1ns/1ps

module parityMerger
    import encPackage::*;
(
    input  logic    iClock,
    input  logic    reset,
    input  logic    iSrcValid,
    input  stream_t seqWord,
    input  crc_t    parityWord,
    input  logic    convReady,
    output logic    srcReady,
    output logic    mergedValid,
    output stream_t mergedWord
);

    mergeState_t state;
    mergeState_t nextState;

    always_ff @(posedge iClock)
    begin
        if (reset)
        begin
            state <= PassData;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState   = state;
        srcReady    = 1'b0;
        mergedValid = 1'b0;
        mergedWord  = seqWord;
        case (state)
            PassData:
            begin
                srcReady    = convReady;
                mergedValid = iSrcValid;
                mergedWord  = seqWord;
                if (iSrcValid && convReady && seqWord.dataLast)
                begin
                    nextState = EmitParity;
                end
            end
            EmitParity:
            begin
                // The host is held off while the parity word goes out.
                mergedValid           = 1'b1;
                mergedWord.data       = parityWord;
                mergedWord.dataLast   = 1'b0;
                mergedWord.parityLast = 1'b1;
                if (convReady)
                begin
                    nextState = PassData;
                end
            end
            default:
            begin
                nextState = PassData;
            end
        endcase
    end

    noHostInParity: assert property (
        @(posedge iClock) disable iff (reset)
        (state == EmitParity) |-> !srcReady
    );

endmodule

// File: crcParityEncoder.sv
`timescale 1ns/1ps

module crcParityEncoder
    import encPackage::*;
(
    input  logic    iClock,
    input  logic    reset,
    input  logic    seqStrobe,
    input  stream_t seqWord,
    output crc_t    parityWord
);

    crc_t crcReg;
    crc_t crcNext;

    // Sixteen serial LFSR steps, one per data bit, MSB first.
    function automatic crc_t crcUpdate(input crc_t crcIn, input halfWord_t word);
        crc_t crc;
        logic feedback;
        crc = crcIn;
        for (int i = 15; i >= 0; i--)
        begin
            feedback = crc[15] ^ word[i];
            crc = {crc[14:0], 1'b0};
            if (feedback)
            begin
                crc = crc ^ CrcPoly;
            end
        end
        return crc;
    endfunction

    assign crcNext = crcUpdate(crcReg, seqWord.data);

    always_ff @(posedge iClock)
    begin
        if (reset)
        begin
            crcReg <= CrcInit;
        end
        else if (seqStrobe)
        begin
            // The last word closes the chunk, so the next one starts fresh.
            if (seqWord.dataLast)
            begin
                crcReg <= CrcInit;
            end
            else
            begin
                crcReg <= crcNext;
            end
        end
    end

    always_ff @(posedge iClock)
    begin
        if (seqStrobe && seqWord.dataLast)
        begin
            parityWord <= crcNext;
        end
    end

endmodule

// File: chunkSequencer.sv
`timescale 1ns/1ps

module chunkSequencer
    import encPackage::*;
(
    input  logic      iClock,
    input  logic      reset,
    input  logic      iSrcValid,
    input  halfWord_t iSrcData,
    input  logic      srcReady,
    output logic      seqStrobe,
    output stream_t   seqWord
);

    chunkCount_t wordCount;
    logic        lastWord;

    // A host word is taken whenever both sides agree in the same cycle.
    assign seqStrobe = iSrcValid && srcReady;

    assign lastWord = (wordCount == LastWordIndex);

    always_comb
    begin
        seqWord.data       = iSrcData;
        seqWord.dataLast   = lastWord;
        seqWord.parityLast = 1'b0;
    end

    // Count accepted words and wrap after the last word of the chunk.
    always_ff @(posedge iClock)
    begin
        if (reset)
        begin
            wordCount <= '0;
        end
        else if (seqStrobe)
        begin
            if (lastWord)
            begin
                wordCount <= '0;
            end
            else
            begin
                wordCount <= wordCount + 1'b1;
            end
        end
    end

    // The index stays within the chunk across any run of accepted words.
    countInRange: assert property (
        @(posedge iClock) disable iff (reset)
        wordCount <= LastWordIndex
    );

endmodule

// File: encPackage.sv
package encPackage;

    // A stream word carries either host data or the parity of a chunk.
    typedef logic [15:0] halfWord_t;

    // One beat on the channel bus holds two stream words.
    typedef logic [31:0] beat_t;

    // Word index inside a chunk.
    typedef logic [2:0] chunkCount_t;

    typedef logic [15:0] crc_t;

    // Number of host data words that make up one chunk.
    localparam int ChunkDataWords = 7;

    // Index of the word that closes a chunk.
    localparam chunkCount_t LastWordIndex = chunkCount_t'(ChunkDataWords - 1);

    // CRC-16 generator x^16 + x^12 + x^5 + 1, shifted in MSB first.
    localparam crc_t CrcPoly = 16'h1021;

    localparam crc_t CrcInit = 16'hFFFF;

    // A stream word with its framing flags.
    typedef struct packed
    {
        halfWord_t data;
        logic      dataLast;
        logic      parityLast;
    } stream_t;

    // Width converter states, one-hot.
    typedef enum logic [4:0]
    {
        Idle     = 5'b00001,
        Input    = 5'b00010,
        Shift    = 5'b00100,
        InPause  = 5'b01000,
        OutPause = 5'b10000
    } convState_t;

    // The merger either passes host data or inserts the parity word.
    typedef enum logic
    {
        PassData   = 1'b0,
        EmitParity = 1'b1
    } mergeState_t;

endpackage
